// ==== icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// geometry of the 16 KiB four-way cache
`define ICACHE_ADDR_W 32
`define ICACHE_WORDS 8
`define ICACHE_WAYS 4
`define ICACHE_SETS 128

// field widths
`define ICACHE_OFF_W 3
`define ICACHE_SET_W 7
`define ICACHE_TAG_W 20

// bit positions of the fields in an address
`define ICACHE_OFF_LSB 2
`define ICACHE_SET_LSB (`ICACHE_OFF_LSB + `ICACHE_OFF_W)
`define ICACHE_TAG_LSB (`ICACHE_SET_LSB + `ICACHE_SET_W)

// line address as sent to memory
`define ICACHE_LINE_ADDR_W (`ICACHE_TAG_W + `ICACHE_SET_W)

`endif

// ==== icache_pkg.sv ====
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

	typedef logic [31:0] word_t;
	typedef logic [`ICACHE_SET_W-1:0] set_t;
	typedef logic [`ICACHE_OFF_W-1:0] off_t;
	typedef logic [`ICACHE_WAYS-1:0] way_oh_t;

	typedef struct packed {
		logic valid;
		logic [`ICACHE_TAG_W-1:0] tag;
	} tag_entry_t;

	typedef word_t [`ICACHE_WORDS-1:0] line_t;
	typedef tag_entry_t [`ICACHE_WAYS-1:0] tag_set_t;
	typedef line_t [`ICACHE_WAYS-1:0] line_set_t;

	// one burst per miss, wraps from start_off
	typedef struct packed {
		logic valid;
		logic [`ICACHE_LINE_ADDR_W-1:0] line_addr;
		off_t start_off;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic last; // eighth beat
		word_t data;
	} mem_resp_t;

	typedef struct packed {
		logic valid;
		logic hit;
		way_oh_t way_oh; // zero on a miss
		set_t set;
		logic [`ICACHE_TAG_W-1:0] tag; // from the physical address
		off_t off;
	} look_t;

	// shared by the sweep and the refill
	typedef struct packed {
		logic we;
		set_t set;
		way_oh_t way_oh;
		tag_entry_t tag_entry;
	} fill_t;

endpackage

`default_nettype wire

// ==== icache_sync_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_sync_ram #(
	parameter int DEPTH = 128,
	parameter type T = logic
) (
	input logic i_clk,
	input logic i_we,
	input icache_pkg::set_t i_waddr,
	input icache_pkg::set_t i_raddr,
	input T i_wdata,
	output T o_rdata
);

	T mem [DEPTH];

	// read during write returns the old entry
	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
		o_rdata <= mem[i_raddr];
	end

endmodule

`default_nettype wire

// ==== icache_plru.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_plru (
	input logic i_clk,
	input logic i_rst,
	input icache_pkg::look_t i_look,
	input logic i_miss,
	output icache_pkg::way_oh_t o_victim
);

	// bit 0 root (0 = ways 0/1), bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
	logic [`ICACHE_SETS-1:0][2:0] tree_q;
	logic [2:0] cur_bits;
	logic [2:0] next_bits;
	icache_pkg::way_oh_t used_way;

	function automatic icache_pkg::way_oh_t pick_victim(input logic [2:0] b);
		if (!b[0]) begin
			pick_victim = b[1] ? 4'b0010 : 4'b0001;
		end else begin
			pick_victim = b[2] ? 4'b1000 : 4'b0100;
		end
	endfunction

	function automatic logic [2:0] touch(input logic [2:0] b, input icache_pkg::way_oh_t w);
		logic [2:0] t;
		t = b;
		if (w[0] || w[1]) begin
			t[0] = 1'b1; // root away from the used half
			t[1] = w[0]; // leaf to the sibling
		end else begin
			t[0] = 1'b0;
			t[2] = w[2];
		end
		return t;
	endfunction

	assign cur_bits = tree_q[i_look.set];
	assign o_victim = pick_victim(cur_bits);
	assign used_way = i_miss ? o_victim : i_look.way_oh;
	assign next_bits = touch(cur_bits, used_way);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			tree_q <= '0;
		end else if (i_miss || (i_look.valid && i_look.hit)) begin
			tree_q[i_look.set] <= next_bits;
		end
	end

endmodule

`default_nettype wire

// ==== icache_refill_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_refill_counter (
	input logic i_clk,
	input logic i_rst,
	input logic i_start,
	input icache_pkg::off_t i_start_off,
	input logic i_beat,
	output icache_pkg::off_t o_off,
	output logic o_crit
);

	icache_pkg::off_t off_q;
	icache_pkg::off_t start_q; // requested word

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			off_q <= '0;
			start_q <= '0;
		end else if (i_start) begin
			off_q <= i_start_off;
			start_q <= i_start_off;
		end else if (i_beat) begin
			off_q <= off_q + 3'd1; // wraps within the line
		end
	end

	assign o_off = off_q;

	// first beat of the burst carries the requested word
	assign o_crit = i_beat && (off_q == start_q);

endmodule

`default_nettype wire

// ==== icache_refill_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_refill_buf (
	input logic i_clk,
	input icache_pkg::mem_resp_t i_beat,
	input icache_pkg::off_t i_off,
	input logic i_crit,
	output icache_pkg::line_t o_line,
	output logic o_crit_valid,
	output icache_pkg::word_t o_crit_data
);

	icache_pkg::line_t words_q;

	always_ff @(posedge i_clk) begin
		if (i_beat.valid) begin
			words_q[i_off] <= i_beat.data;
		end
	end

	// whole line goes to the line RAMs in the refill cycle
	assign o_line = words_q;

	// early restart straight from the beat
	assign o_crit_valid = i_crit && i_beat.valid;
	assign o_crit_data = i_beat.data;

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_ctrl (
	input logic i_clk,
	input logic i_rst,
	input icache_pkg::look_t i_look,
	input icache_pkg::way_oh_t i_victim,
	input icache_pkg::mem_resp_t i_beat,
	output logic o_stall,
	output icache_pkg::mem_req_t o_mem_req,
	output logic o_start,
	output icache_pkg::off_t o_start_off,
	output icache_pkg::fill_t o_fill,
	output logic o_plru_miss
);

	typedef enum logic [2:0] {
		SWEEP,
		IDLE,
		REQUEST,
		RECEIVE,
		REFILL
	} state_t;

	state_t state_q;
	state_t state_d;
	icache_pkg::set_t sweep_q;
	icache_pkg::set_t miss_set_q;
	logic [`ICACHE_TAG_W-1:0] miss_tag_q;
	icache_pkg::off_t miss_off_q;
	icache_pkg::way_oh_t miss_way_q;
	logic miss;

	assign miss = (state_q == IDLE) && i_look.valid && !i_look.hit;

	always_comb begin
		state_d = state_q;
		case (state_q)
			SWEEP: begin
				if (sweep_q == icache_pkg::set_t'(`ICACHE_SETS - 1)) begin
					state_d = IDLE;
				end
			end
			IDLE: begin
				if (miss) begin
					state_d = REQUEST;
				end
			end
			REQUEST: state_d = RECEIVE;
			RECEIVE: begin
				if (i_beat.valid && i_beat.last) begin
					state_d = REFILL;
				end
			end
			REFILL: state_d = IDLE;
			default: state_d = SWEEP;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= SWEEP;
			sweep_q <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == SWEEP) begin
				sweep_q <= sweep_q + 1'b1;
			end
		end
	end

	// miss context, held until the refill write
	always_ff @(posedge i_clk) begin
		if (miss) begin
			miss_set_q <= i_look.set;
			miss_tag_q <= i_look.tag;
			miss_off_q <= i_look.off;
			miss_way_q <= i_victim;
		end
	end

	assign o_stall = (state_q != IDLE) || miss;
	assign o_plru_miss = miss; // victim counts as used
	assign o_start = (state_q == REQUEST);
	assign o_start_off = miss_off_q;

	always_comb begin
		o_mem_req.valid = (state_q == REQUEST);
		o_mem_req.line_addr = {miss_tag_q, miss_set_q};
		o_mem_req.start_off = miss_off_q;
	end

	always_comb begin
		o_fill = '0;
		if (state_q == SWEEP) begin
			o_fill.we = 1'b1;
			o_fill.set = sweep_q;
			o_fill.way_oh = '1; // all ways to invalid
		end else if (state_q == REFILL) begin
			o_fill.we = 1'b1;
			o_fill.set = miss_set_q;
			o_fill.way_oh = miss_way_q;
			o_fill.tag_entry.valid = 1'b1;
			o_fill.tag_entry.tag = miss_tag_q;
		end
	end

endmodule

`default_nettype wire

// ==== icache_lookup.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_lookup (
	input logic i_clk,
	input logic i_rst,
	input logic i_valid,
	input icache_pkg::word_t i_va,
	input icache_pkg::word_t i_pa,
	input logic i_stall,
	input icache_pkg::tag_set_t i_tags,
	input icache_pkg::line_set_t i_lines,
	input logic i_crit_valid,
	input icache_pkg::word_t i_crit_data,
	output icache_pkg::set_t o_raddr,
	output icache_pkg::look_t o_look,
	output logic o_valid,
	output icache_pkg::word_t o_data
);

	logic s1_valid_q;
	icache_pkg::word_t s1_va_q;
	icache_pkg::way_oh_t hit_vec;
	logic [`ICACHE_TAG_W-1:0] pa_tag;
	icache_pkg::off_t s1_off;
	icache_pkg::word_t hit_word;

	// RAMs are indexed by the virtual address
	assign o_raddr = i_va[`ICACHE_TAG_LSB-1:`ICACHE_SET_LSB];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			s1_valid_q <= 1'b0;
		end else begin
			s1_valid_q <= i_valid && !i_stall;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_stall) begin
			s1_va_q <= i_va;
		end
	end

	assign pa_tag = i_pa[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
	assign s1_off = s1_va_q[`ICACHE_SET_LSB-1:`ICACHE_OFF_LSB];

	// tag compare and word select
	always_comb begin
		hit_word = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit_vec[w] = i_tags[w].valid && (i_tags[w].tag == pa_tag);
			if (hit_vec[w]) begin
				hit_word = hit_word | i_lines[w][s1_off];
			end
		end
	end

	always_comb begin
		o_look.valid = s1_valid_q;
		o_look.hit = |hit_vec;
		o_look.way_oh = hit_vec;
		o_look.set = s1_va_q[`ICACHE_TAG_LSB-1:`ICACHE_SET_LSB];
		o_look.tag = pa_tag;
		o_look.off = s1_off;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_crit_valid || (s1_valid_q && o_look.hit);
		end
	end

	// critical word wins, no hit can be pending then
	always_ff @(posedge i_clk) begin
		if (i_crit_valid) begin
			o_data <= i_crit_data;
		end else if (s1_valid_q) begin
			o_data <= hit_word;
		end
	end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module icache_top (
	input logic i_clk,
	input logic i_rst,
	input logic i_valid,
	input icache_pkg::word_t i_va,
	input icache_pkg::word_t i_pa,
	output logic o_stall,
	output logic o_valid,
	output icache_pkg::word_t o_data,
	output icache_pkg::mem_req_t o_mem_req,
	input icache_pkg::mem_resp_t i_mem_resp
);

	icache_pkg::set_t raddr;
	icache_pkg::tag_set_t tags;
	icache_pkg::line_set_t lines;
	icache_pkg::look_t look;
	icache_pkg::way_oh_t victim;
	icache_pkg::fill_t fill;
	icache_pkg::line_t fill_line;
	icache_pkg::off_t start_off;
	icache_pkg::off_t beat_off;
	icache_pkg::word_t crit_data;
	logic start;
	logic crit;
	logic crit_valid;
	logic plru_miss;

	icache_lookup u_lookup (
		.i_clk,
		.i_rst,
		.i_valid,
		.i_va,
		.i_pa,
		.i_stall(o_stall),
		.i_tags(tags),
		.i_lines(lines),
		.i_crit_valid(crit_valid),
		.i_crit_data(crit_data),
		.o_raddr(raddr),
		.o_look(look),
		.o_valid,
		.o_data
	);

	icache_ctrl u_ctrl (
		.i_clk,
		.i_rst,
		.i_look(look),
		.i_victim(victim),
		.i_beat(i_mem_resp),
		.o_stall,
		.o_mem_req,
		.o_start(start),
		.o_start_off(start_off),
		.o_fill(fill),
		.o_plru_miss(plru_miss)
	);

	icache_refill_counter u_cnt (
		.i_clk,
		.i_rst,
		.i_start(start),
		.i_start_off(start_off),
		.i_beat(i_mem_resp.valid),
		.o_off(beat_off),
		.o_crit(crit)
	);

	icache_refill_buf u_buf (
		.i_clk,
		.i_beat(i_mem_resp),
		.i_off(beat_off),
		.i_crit(crit),
		.o_line(fill_line),
		.o_crit_valid(crit_valid),
		.o_crit_data(crit_data)
	);

	icache_plru u_plru (
		.i_clk,
		.i_rst,
		.i_look(look),
		.i_miss(plru_miss),
		.o_victim(victim)
	);

	for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
		icache_sync_ram #(
			.DEPTH(`ICACHE_SETS),
			.T(icache_pkg::tag_entry_t)
		) u_tag_ram (
			.i_clk,
			.i_we(fill.we && fill.way_oh[g]),
			.i_waddr(fill.set),
			.i_raddr(raddr),
			.i_wdata(fill.tag_entry),
			.o_rdata(tags[g])
		);

		icache_sync_ram #(
			.DEPTH(`ICACHE_SETS),
			.T(icache_pkg::line_t)
		) u_line_ram (
			.i_clk,
			.i_we(fill.we && fill.way_oh[g]),
			.i_waddr(fill.set),
			.i_raddr(raddr),
			.i_wdata(fill_line),
			.o_rdata(lines[g])
		);
	end

endmodule

`default_nettype wire

// ==== tb_icache_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module tb_icache_mem (
	input logic i_clk,
	input icache_pkg::mem_req_t i_req,
	output icache_pkg::mem_resp_t o_resp
);

	integer seed;
	logic [31:0] rnd;
	logic [1:0] gap;
	logic [`ICACHE_LINE_ADDR_W-1:0] line;
	icache_pkg::off_t off;
	int beat;

	// data of a word follows its byte address
	function automatic icache_pkg::word_t word_at(
		input logic [`ICACHE_LINE_ADDR_W-1:0] l,
		input icache_pkg::off_t o
	);
		return {l, o, 2'b00} ^ 32'h5a5a0000;
	endfunction

	initial begin
		seed = 32'hffc1;
		o_resp = '0;
		forever begin
			@(negedge i_clk);
			o_resp = '0;
			if (i_req.valid) begin
				line = i_req.line_addr;
				off = i_req.start_off;
				for (beat = 0; beat < `ICACHE_WORDS; beat++) begin
					rnd = $random(seed);
					gap = rnd[1:0]; // 0 to 3 idle cycles
					repeat (gap) begin
						@(negedge i_clk);
						o_resp = '0;
					end
					@(negedge i_clk);
					o_resp.valid = 1'b1;
					o_resp.last = (beat == `ICACHE_WORDS - 1);
					o_resp.data = word_at(line, off);
					off = off + 3'd1; // wraps around the line
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_config.svh"

module tb_icache;

	// reset, sweep, up to 20 refills of 40 cycles and slack, then doubled
	localparam int WATCHDOG_NS = 10 * 2 * (16 + `ICACHE_SETS + 20 * 40 + 56);
	localparam int MAX_WAIT = 100;
	localparam icache_pkg::set_t PLRU_SET = 7'h2a;
	localparam logic [`ICACHE_TAG_W-1:0] TAG0 = 20'h00100;

	logic i_clk;
	logic i_rst;
	logic i_valid;
	icache_pkg::word_t i_va;
	icache_pkg::word_t i_pa;
	logic o_stall;
	logic o_valid;
	icache_pkg::word_t o_data;
	icache_pkg::mem_req_t o_mem_req;
	icache_pkg::mem_resp_t i_mem_resp;

	logic stall_s;
	logic valid_s;
	icache_pkg::word_t data_s;
	icache_pkg::mem_req_t req_s;
	logic acc; // request taken at the coming edge
	icache_pkg::word_t acc_va;

	logic [2:0] tree; // [0] root, 1 = right half next; [1] ways 0/1; [2] ways 2/3
	logic [`ICACHE_TAG_W-1:0] way_tag [4];
	logic [3:0] way_used;
	logic [`ICACHE_TAG_W-1:0] evicted_tag;

	icache_top UUT (
		.i_clk,
		.i_rst,
		.i_valid,
		.i_va,
		.i_pa,
		.o_stall,
		.o_valid,
		.o_data,
		.o_mem_req,
		.i_mem_resp
	);

	tb_icache_mem u_mem (
		.i_clk,
		.i_req(o_mem_req),
		.o_resp(i_mem_resp)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		report_error("watchdog expired before the tests finished");
	end

	task automatic report_error(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input icache_pkg::word_t got,
			input icache_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_req(input string name, input icache_pkg::mem_req_t got,
			input icache_pkg::mem_req_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1, "request mismatch");
		end
	endtask

	function automatic icache_pkg::word_t exp_word(input icache_pkg::word_t va);
		return {va[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'h5a5a0000;
	endfunction

	function automatic icache_pkg::mem_req_t exp_req(input icache_pkg::word_t va);
		icache_pkg::mem_req_t r;
		r.valid = 1'b1;
		r.line_addr = va[`ICACHE_ADDR_W-1:`ICACHE_SET_LSB];
		r.start_off = va[`ICACHE_SET_LSB-1:`ICACHE_OFF_LSB]; // burst starts at the word
		return r;
	endfunction

	task automatic capture_outputs();
		stall_s = o_stall;
		valid_s = o_valid;
		data_s = o_data;
		req_s = o_mem_req;
	endtask

	// drive on the falling edge, sample once things settle
	task automatic step(input logic valid, input icache_pkg::word_t va);
		@(negedge i_clk);
		if (acc) begin
			i_pa = acc_va; // translation arrives one cycle later
		end
		i_valid = valid;
		i_va = va;
		#1;
		capture_outputs();
		acc = valid && !o_stall;
		acc_va = va;
	endtask

	task automatic fetch(input icache_pkg::word_t va, input logic exp_miss);
		int n;
		int reqs;
		int valids;
		logic early;
		n = 0;
		reqs = 0;
		valids = 0;
		early = 1'b0;
		do begin
			step(1'b1, va);
			n++;
			if (n > MAX_WAIT) report_error("request never accepted");
		end while (!acc);
		n = 0;
		do begin
			step(1'b0, '0);
			n++;
			if (req_s.valid) begin
				reqs++;
				check_req("o_mem_req", req_s, exp_req(va));
			end
			if (valid_s) begin
				valids++;
				early = stall_s;
				check_word("o_data", data_s, exp_word(va));
				if (!exp_miss && n != 2) report_error("hit data not two cycles after acceptance");
			end
			if (n > MAX_WAIT) report_error("no data returned for a request");
		end while (valids == 0 || stall_s);
		if (reqs != (exp_miss ? 1 : 0)) report_error("memory request count does not match hit/miss");
		if (valids != 1) report_error("o_valid pulsed more than once for one request");
		if (exp_miss && !early) report_error("critical word came after the stall dropped");
	endtask

	task automatic test_sweep();
		int n;
		n = 0;
		while (stall_s) begin
			n++;
			if (valid_s || req_s.valid) report_error("output strobe during the sweep");
			if (n > 2 * `ICACHE_SETS) report_error("o_stall stuck high after reset");
			step(1'b0, '0);
		end
		if (n != `ICACHE_SETS) report_error($sformatf("sweep lasted %0d cycles", n));
		fetch(32'h0000_1008, 1'b1); // cold cache misses
	endtask

	task automatic test_miss();
		fetch(32'h0004_0a34, 1'b1); // word 5 of its line
	endtask

	task automatic test_hits();
		icache_pkg::word_t base;
		icache_pkg::word_t va;
		int k;
		base = 32'h0004_0a20;
		for (k = 0; k < `ICACHE_WORDS + 2; k++) begin
			va = base + k * 4;
			step(k < `ICACHE_WORDS, va);
			if (k < `ICACHE_WORDS && !acc) report_error("back-to-back hit not accepted");
			if (req_s.valid) report_error("memory request during hits");
			if (k >= 2) begin
				if (!valid_s) report_error("o_valid missing for a back-to-back hit");
				check_word("o_data", data_s, exp_word(base + (k - 2) * 4));
			end else if (valid_s) begin
				report_error("o_valid too early");
			end
		end
	endtask

	task automatic test_stall_hold();
		icache_pkg::word_t miss_va;
		icache_pkg::word_t hit_va;
		int n;
		int reqs;
		int valids;
		miss_va = 32'h0008_07c8;
		hit_va = 32'h0004_0a28; // line filled earlier
		n = 0;
		reqs = 0;
		valids = 0;
		step(1'b1, miss_va);
		if (!acc) report_error("miss request not accepted");
		do begin
			step(1'b1, hit_va);
			n++;
			if (n == 1 && acc) report_error("request accepted while a miss was in stage two");
			if (valid_s) begin
				valids++;
				check_word("o_data", data_s, exp_word(miss_va));
			end
			if (req_s.valid) begin
				reqs++;
				check_req("o_mem_req", req_s, exp_req(miss_va));
			end
			if (n > MAX_WAIT) report_error("held request never accepted");
		end while (!acc);
		if (reqs != 1 || valids != 1) report_error("miss not served once before the held request");
		step(1'b0, '0);
		step(1'b0, '0);
		if (!valid_s) report_error("held request returned no data");
		check_word("o_data", data_s, exp_word(hit_va));
	endtask

	function automatic int victim_way();
		if (!tree[0]) begin
			return tree[1] ? 1 : 0;
		end
		return tree[2] ? 3 : 2;
	endfunction

	task automatic touch_way(input int w);
		if (w < 2) begin
			tree[0] = 1'b1; // point at the other half
			tree[1] = (w == 0);
		end else begin
			tree[0] = 1'b0;
			tree[2] = (w == 2);
		end
	endtask

	// model predicts hit or miss, DUT must agree
	task automatic plru_access(input logic [`ICACHE_TAG_W-1:0] tag);
		icache_pkg::word_t va;
		int w;
		int way;
		way = -1;
		for (w = 0; w < `ICACHE_WAYS; w++) begin
			if (way_used[w] && way_tag[w] == tag) begin
				way = w;
			end
		end
		va = {tag, PLRU_SET, 3'd6, 2'b00};
		fetch(va, way < 0);
		if (way < 0) begin
			way = victim_way();
			evicted_tag = way_tag[way];
			way_tag[way] = tag;
			way_used[way] = 1'b1;
		end
		touch_way(way);
	endtask

	task automatic test_plru();
		logic [`ICACHE_TAG_W-1:0] gone;
		int k;
		tree = '0;
		way_used = '0;
		for (k = 0; k < 4; k++) begin
			plru_access(TAG0 + 20'(k));
		end
		plru_access(TAG0);
		plru_access(TAG0 + 20'(3));
		plru_access(TAG0 + 20'(4)); // fifth line replaces one
		gone = evicted_tag;
		for (k = 0; k < 5; k++) begin
			if (TAG0 + 20'(k) != gone) begin
				plru_access(TAG0 + 20'(k));
			end
		end
		plru_access(gone);
	endtask

	initial begin
		i_rst = 1'b1;
		i_valid = 1'b0;
		i_va = '0;
		i_pa = '0;
		acc = 1'b0;
		acc_va = '0;
		repeat (16) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		#1;
		capture_outputs();
		test_sweep();
		test_miss();
		test_hits();
		test_stall_hold();
		test_plru();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
icache_pkg.sv
icache_sync_ram.sv
icache_plru.sv
icache_refill_counter.sv
icache_refill_buf.sv
icache_ctrl.sv
icache_lookup.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS := --timing --timescale 1ns/1ns
TOP := tb_icache
RTL_TOP := icache_top
FILELIST := vlog.f
OBJ_DIR := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
